// File: include/pci_master_config.svh
// Sizes of the master write path; PCI_BUF_DEPTH must equal 2**PCI_BUF_ADDR_WIDTH
`ifndef PCI_MASTER_CONFIG_SVH
`define PCI_MASTER_CONFIG_SVH

// Width of the multiplexed address/data bus
`define PCI_AD_WIDTH 32

// Host write buffer, one entry per data phase of a burst
`define PCI_BUF_DEPTH 16
`define PCI_BUF_ADDR_WIDTH 4

// FRAME cycles after which the master must give up the bus once GNT is gone
`define PCI_LAT_TIMER_LIMIT 8

`endif

// File: src/pci_master_pkg.sv
// Shared types of the master write path; bus signals are active-high levels here
`include "pci_master_config.svh"

package pci_master_pkg;

  // Next-FRAME codes, encoded as in the pad library
  typedef enum logic [2:0] {
    FRAME_0            = 3'd0,
    FRAME_UNLESS_STOP  = 3'd1,
    FRAME_UNLESS_LAST  = 3'd2,
    FRAME_WHILE_WAIT   = 3'd3,
    FRAME_BACK_TO_BACK = 3'd4,
    FRAME_1            = 3'd5
  } frame_code_e;

  // Next-IRDY codes
  typedef enum logic [2:0] {
    IRDY_0           = 3'd0,
    IRDY_IF_STOP     = 3'd1,
    IRDY_UNLESS_MORE = 3'd2,
    IRDY_WHILE_WAIT  = 3'd3,
    IRDY_1           = 3'd4
  } irdy_code_e;

  // Target response as seen on the bus in the current cycle
  typedef struct packed {
    logic trdy;
    logic stop;
  } bus_resp_t;

  // What the sequencer asks of the late-select decoder
  typedef struct packed {
    frame_code_e frame_code;
    irdy_code_e  irdy_code;
    logic        load_unconditional;
  } next_codes_t;

  // Everything the output pad bank needs for the next clock
  typedef struct packed {
    logic [`PCI_AD_WIDTH-1:0] ad_next;
    logic                     ad_en_next;
    logic                     frame_next;
    logic                     irdy_next;
    logic                     ad_oe_next;
    logic                     ctl_oe_next;
  } pad_next_t;

endpackage

// File: src/pci_next_signal_decode.sv
// Purely combinational; trdy and stop arrive late and only steer the final 4:1 select
`timescale 1ns/1ns
`include "pci_master_config.svh"

module pci_next_signal_decode (
  input  pci_master_pkg::next_codes_t codes,
  input  pci_master_pkg::bus_resp_t   pci_resp,
  input  logic                        pci_irdy_out,
  input  logic                        sel_addr,
  input  logic [`PCI_AD_WIDTH-1:0]    host_addr,
  input  logic [`PCI_AD_WIDTH-1:0]    ad_word,
  input  logic                        ad_oe_next,
  input  logic                        ctl_oe_next,
  output pci_master_pkg::pad_next_t   pad_next
);
  import pci_master_pkg::*;

  // Each row holds the output for {last, more, abort, idle}, bit 0 being idle
  logic [3:0] frame_row;
  logic [3:0] irdy_row;

  // Late 4:1 select, stop first and trdy last, so trdy sees a single mux level
  function automatic logic late_select(input logic [3:0] row, input bus_resp_t resp);
    logic abort_idle;
    logic last_more;
    abort_idle = resp.stop ? row[1] : row[0];
    last_more = resp.stop ? row[3] : row[2];
    return resp.trdy ? last_more : abort_idle;
  endfunction

  // ====================================================================
  // Early part of the decode, settled long before trdy and stop
  // ====================================================================
  always_comb
  begin
    case (codes.frame_code)
      FRAME_0:            frame_row = 4'b0000;
      FRAME_UNLESS_STOP:  frame_row = 4'b1101;
      FRAME_UNLESS_LAST:  frame_row = 4'b0101;
      FRAME_WHILE_WAIT:   frame_row = 4'b0001;
      FRAME_BACK_TO_BACK: frame_row = 4'b1100;
      FRAME_1:            frame_row = 4'b1111;
      default:            frame_row = 4'b0000;
    endcase
    case (codes.irdy_code)
      IRDY_0:           irdy_row = 4'b0000;
      IRDY_IF_STOP:     irdy_row = 4'b0010;
      IRDY_UNLESS_MORE: irdy_row = 4'b1001;
      IRDY_WHILE_WAIT:  irdy_row = 4'b0001;
      IRDY_1:           irdy_row = 4'b1111;
      default:          irdy_row = 4'b0000;
    endcase
    // The sequencer only ever issues named codes, so the default rows stay dead
    assert (codes.frame_code <= FRAME_1 && codes.irdy_code <= IRDY_1)
      else $error("illegal next-signal code %0d/%0d", codes.frame_code, codes.irdy_code);
  end

  // ====================================================================
  // Late part, assembled into the pad word
  // ====================================================================
  always_comb
  begin
    // Address goes out only in the address phase, buffer data otherwise
    pad_next.ad_next = sel_addr ? host_addr : ad_word;
    // AD moves on a completed data phase or when the sequencer forces a load
    pad_next.ad_en_next = (pci_irdy_out & pci_resp.trdy) | codes.load_unconditional;
    pad_next.frame_next = late_select(frame_row, pci_resp);
    pad_next.irdy_next = late_select(irdy_row, pci_resp);
    pad_next.ad_oe_next = ad_oe_next;
    pad_next.ctl_oe_next = ctl_oe_next;
  end

endmodule

// File: src/pci_latency_timer.sv
// Counts pci_clk cycles of FRAME only; expired stays high until FRAME drops
`timescale 1ns/1ns
`include "pci_master_config.svh"

module pci_latency_timer (
  input  logic pci_clk,
  input  logic pci_reset_comb,
  input  logic pci_frame_out,
  output logic expired
);

  localparam int LIMIT = `PCI_LAT_TIMER_LIMIT;
  localparam int CNT_W = $clog2(LIMIT + 1);

  logic [CNT_W-1:0] count;

  // Saturates at the limit instead of wrapping
  assign expired = (count == CNT_W'(LIMIT));

  always_ff @(posedge pci_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
      count <= '0;
    else if (!pci_frame_out)
      // A new transaction starts with a fresh time slice
      count <= '0;
    else if (!expired)
      count <= count + 1'b1;
  end

endmodule

// File: src/pci_write_buffer.sv
// No host writes during a burst; the read word is only valid while buf_count is nonzero
`timescale 1ns/1ns
`include "pci_master_config.svh"

module pci_write_buffer (
  input  logic                          pci_clk,
  input  logic                          pci_reset_comb,
  input  logic                          host_write,
  input  logic [`PCI_AD_WIDTH-1:0]      host_wdata,
  input  logic                          rd_advance,
  input  logic                          buf_clear,
  output logic [`PCI_AD_WIDTH-1:0]      rd_word,
  output logic [`PCI_BUF_ADDR_WIDTH:0]  buf_count,
  output logic                          buf_last
);

  localparam logic [`PCI_BUF_ADDR_WIDTH:0] FULL_COUNT =
    (`PCI_BUF_ADDR_WIDTH + 1)'(`PCI_BUF_DEPTH);

  logic [`PCI_AD_WIDTH-1:0]      mem [0:`PCI_BUF_DEPTH-1];
  logic [`PCI_BUF_ADDR_WIDTH-1:0] wr_ptr;
  logic [`PCI_BUF_ADDR_WIDTH-1:0] rd_ptr;

  // Write port, captured on the same edge as host_write
  always_ff @(posedge pci_clk)
  begin
    if (host_write)
      mem[wr_ptr] <= host_wdata;
  end

  // Read address lives in a flop, so the word follows rd_advance by one cycle
  assign rd_word = mem[rd_ptr];
  assign buf_last = (buf_count == 1);

  always_ff @(posedge pci_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      buf_count <= '0;
    end
    else if (buf_clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      buf_count <= '0;
    end
    else
    begin
      if (host_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_advance)
        rd_ptr <= rd_ptr + 1'b1;
      // Count tracks words not yet placed on AD
      case ({host_write, rd_advance})
        2'b10:   buf_count <= buf_count + 1'b1;
        2'b01:   buf_count <= buf_count - 1'b1;
        default: buf_count <= buf_count;
      endcase
    end
  end

  // Host must respect the depth; a full buffer would overwrite the oldest word
  a_no_write_when_full: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    host_write |-> (buf_count < FULL_COUNT));

endmodule

// File: src/pci_output_pads.sv
// Outputs and OEs go to 0 on reset without a clock, as PCI needs with a stopped clock
`timescale 1ns/1ns
`include "pci_master_config.svh"

module pci_output_pads (
  input  logic                      pci_clk,
  input  logic                      pci_reset_comb,
  input  pci_master_pkg::pad_next_t pad_next,
  output logic [`PCI_AD_WIDTH-1:0]  pci_ad_out,
  output logic                      pci_ad_oe,
  output logic                      pci_frame_out,
  output logic                      pci_irdy_out,
  output logic                      pci_ctl_oe
);

  // These flops belong in or next to the IO cells
  always_ff @(posedge pci_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      pci_ad_out <= '0;
      pci_ad_oe <= 1'b0;
      pci_frame_out <= 1'b0;
      pci_irdy_out <= 1'b0;
      pci_ctl_oe <= 1'b0;
    end
    else
    begin
      // AD holds its word through target wait states
      if (pad_next.ad_en_next)
        pci_ad_out <= pad_next.ad_next;
      pci_ad_oe <= pad_next.ad_oe_next;
      pci_frame_out <= pad_next.frame_next;
      pci_irdy_out <= pad_next.irdy_next;
      pci_ctl_oe <= pad_next.ctl_oe_next;
    end
  end

  // IRDY comes from the decoder, its OE from the sequencer, and they must agree
  a_irdy_driven: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    pci_irdy_out |-> pci_ctl_oe);

endmodule

// File: src/pci_master_sequencer.sv
// Bursts need at least one buffered word and a target that leaves trdy low in the address phase
`timescale 1ns/1ns
`include "pci_master_config.svh"

module pci_master_sequencer (
  input  logic                          pci_clk,
  input  logic                          pci_reset_comb,
  input  logic                          host_start,
  input  logic                          pci_gnt,
  input  pci_master_pkg::bus_resp_t     pci_resp,
  input  logic                          pci_frame_out,
  input  logic                          pci_irdy_out,
  input  logic                          expired,
  input  logic [`PCI_BUF_ADDR_WIDTH:0]  buf_count,
  input  logic                          buf_last,
  output pci_master_pkg::next_codes_t   codes,
  output logic                          sel_addr,
  output logic                          ad_oe_next,
  output logic                          ctl_oe_next,
  output logic                          rd_advance,
  output logic                          buf_clear,
  output logic                          xfer_done,
  output logic [`PCI_BUF_ADDR_WIDTH:0]  xfer_words
);
  import pci_master_pkg::*;

  // ST_DATA has FRAME and IRDY high, ST_FINISH is the final data phase
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_FINISH
  } seq_state_e;

  seq_state_e state;
  seq_state_e state_next;
  logic       start_pending;
  logic       ending;
  logic       launch;
  logic       xfer;
  logic       wrap_up;

  // A start waits for GNT and for an idle bus, and not during the clean-up cycle
  assign launch = (state == ST_IDLE) && (host_start || start_pending) && pci_gnt
                  && !pci_frame_out && !pci_irdy_out && !ending;
  assign xfer = pci_irdy_out & pci_resp.trdy;
  // Next transfer must be the final one when a single word is left or the timer ran out without GNT
  assign wrap_up = buf_last | (expired & ~pci_gnt);

  // ====================================================================
  // Code selection
  // ====================================================================
  always_comb
  begin
    codes.frame_code = FRAME_0;
    codes.irdy_code = IRDY_0;
    codes.load_unconditional = 1'b0;
    sel_addr = 1'b0;
    ad_oe_next = 1'b0;
    ctl_oe_next = 1'b0;
    rd_advance = 1'b0;
    buf_clear = 1'b0;
    state_next = state;
    case (state)
      ST_IDLE:
      begin
        // Buffer is emptied in the idle cycle that follows a burst
        buf_clear = ending;
        if (launch)
        begin
          codes.frame_code = FRAME_1;
          codes.load_unconditional = 1'b1;
          sel_addr = 1'b1;
          ad_oe_next = 1'b1;
          ctl_oe_next = 1'b1;
          state_next = ST_ADDR;
        end
      end
      ST_ADDR:
      begin
        // A one-word burst drops FRAME straight into the final data phase
        codes.frame_code = buf_last ? FRAME_0 : FRAME_WHILE_WAIT;
        codes.irdy_code = IRDY_1;
        codes.load_unconditional = 1'b1;
        ad_oe_next = 1'b1;
        ctl_oe_next = 1'b1;
        // First word goes onto AD now, so point the buffer at the second
        rd_advance = 1'b1;
        state_next = buf_last ? ST_FINISH : ST_DATA;
      end
      ST_DATA:
      begin
        codes.frame_code = wrap_up ? FRAME_WHILE_WAIT : FRAME_UNLESS_LAST;
        codes.irdy_code = IRDY_1;
        ad_oe_next = 1'b1;
        ctl_oe_next = 1'b1;
        rd_advance = xfer & (buf_count != '0);
        // Same condition under which the decoder drops FRAME
        if (pci_resp.stop || (pci_resp.trdy && wrap_up))
          state_next = ST_FINISH;
      end
      ST_FINISH:
      begin
        // IRDY holds until the target takes the word or signals STOP
        codes.frame_code = FRAME_0;
        codes.irdy_code = IRDY_WHILE_WAIT;
        ad_oe_next = 1'b1;
        ctl_oe_next = 1'b1;
        rd_advance = xfer & (buf_count != '0);
        if (pci_resp.trdy || pci_resp.stop)
          state_next = ST_IDLE;
      end
      default:
      begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // ====================================================================
  // State, pending start and burst status
  // ====================================================================
  always_ff @(posedge pci_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      state <= ST_IDLE;
      start_pending <= 1'b0;
      ending <= 1'b0;
      xfer_done <= 1'b0;
      xfer_words <= '0;
    end
    else
    begin
      state <= state_next;
      if (launch)
        start_pending <= 1'b0;
      else if (host_start)
        start_pending <= 1'b1;
      // First cycle with FRAME and IRDY both low again
      ending <= (state == ST_FINISH) && (state_next == ST_IDLE);
      // Done comes one cycle after the bus went quiet
      xfer_done <= ending;
      if (launch)
        xfer_words <= '0;
      else if (xfer)
        xfer_words <= xfer_words + 1'b1;
    end
  end

  // The final data phase always has IRDY out and FRAME already gone from the pads
  a_no_frame_in_finish: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (state == ST_FINISH) |-> (pci_irdy_out && !pci_frame_out));

endmodule

// File: src/pci_master_path.sv
// Single pci_clk domain; host_addr must be stable from host_start to the address phase
`timescale 1ns/1ns
`include "pci_master_config.svh"

module pci_master_path (
  input  logic                          pci_clk,
  input  logic                          pci_reset_comb,
  input  logic                          host_write,
  input  logic [`PCI_AD_WIDTH-1:0]      host_wdata,
  input  logic [`PCI_AD_WIDTH-1:0]      host_addr,
  input  logic                          host_start,
  input  logic                          pci_gnt,
  input  pci_master_pkg::bus_resp_t     pci_resp,
  output logic [`PCI_AD_WIDTH-1:0]      pci_ad_out,
  output logic                          pci_ad_oe,
  output logic                          pci_frame_out,
  output logic                          pci_irdy_out,
  output logic                          pci_ctl_oe,
  output logic                          xfer_done,
  output logic [`PCI_BUF_ADDR_WIDTH:0]  xfer_words
);
  import pci_master_pkg::*;

  next_codes_t                   codes;
  pad_next_t                     pad_next;
  logic                          sel_addr;
  logic                          ad_oe_next;
  logic                          ctl_oe_next;
  logic                          rd_advance;
  logic                          buf_clear;
  logic                          expired;
  logic                          buf_last;
  logic [`PCI_AD_WIDTH-1:0]      rd_word;
  logic [`PCI_BUF_ADDR_WIDTH:0]  buf_count;

  // Bus-phase control
  pci_master_sequencer i_sequencer (
    .pci_clk        (pci_clk),
    .pci_reset_comb (pci_reset_comb),
    .host_start     (host_start),
    .pci_gnt        (pci_gnt),
    .pci_resp       (pci_resp),
    .pci_frame_out  (pci_frame_out),
    .pci_irdy_out   (pci_irdy_out),
    .expired        (expired),
    .buf_count      (buf_count),
    .buf_last       (buf_last),
    .codes          (codes),
    .sel_addr       (sel_addr),
    .ad_oe_next     (ad_oe_next),
    .ctl_oe_next    (ctl_oe_next),
    .rd_advance     (rd_advance),
    .buf_clear      (buf_clear),
    .xfer_done      (xfer_done),
    .xfer_words     (xfer_words)
  );

  // Late trdy/stop select in front of the pads
  pci_next_signal_decode i_decode (
    .codes        (codes),
    .pci_resp     (pci_resp),
    .pci_irdy_out (pci_irdy_out),
    .sel_addr     (sel_addr),
    .host_addr    (host_addr),
    .ad_word      (rd_word),
    .ad_oe_next   (ad_oe_next),
    .ctl_oe_next  (ctl_oe_next),
    .pad_next     (pad_next)
  );

  pci_latency_timer i_timer (
    .pci_clk        (pci_clk),
    .pci_reset_comb (pci_reset_comb),
    .pci_frame_out  (pci_frame_out),
    .expired        (expired)
  );

  pci_write_buffer i_buffer (
    .pci_clk        (pci_clk),
    .pci_reset_comb (pci_reset_comb),
    .host_write     (host_write),
    .host_wdata     (host_wdata),
    .rd_advance     (rd_advance),
    .buf_clear      (buf_clear),
    .rd_word        (rd_word),
    .buf_count      (buf_count),
    .buf_last       (buf_last)
  );

  pci_output_pads i_pads (
    .pci_clk        (pci_clk),
    .pci_reset_comb (pci_reset_comb),
    .pad_next       (pad_next),
    .pci_ad_out     (pci_ad_out),
    .pci_ad_oe      (pci_ad_oe),
    .pci_frame_out  (pci_frame_out),
    .pci_irdy_out   (pci_irdy_out),
    .pci_ctl_oe     (pci_ctl_oe)
  );

endmodule

// File: bench/tb_pci_master_path.sv
// Target and arbiter are modelled here; the host writes only between bursts, all on pci_clk
`timescale 1ns/1ns
`include "pci_master_config.svh"

module tb_pci_master_path;
  import pci_master_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int LIMIT = `PCI_LAT_TIMER_LIMIT;

  logic                         pci_clk;
  logic                         pci_reset_comb;
  logic                         host_write;
  logic [`PCI_AD_WIDTH-1:0]     host_wdata;
  logic [`PCI_AD_WIDTH-1:0]     host_addr;
  logic                         host_start;
  logic                         pci_gnt;
  bus_resp_t                    pci_resp;
  logic [`PCI_AD_WIDTH-1:0]     pci_ad_out;
  logic                         pci_ad_oe;
  logic                         pci_frame_out;
  logic                         pci_irdy_out;
  logic                         pci_ctl_oe;
  logic                         xfer_done;
  logic [`PCI_BUF_ADDR_WIDTH:0] xfer_words;

  // Words of the current burst, in the order the host wrote them
  logic [`PCI_AD_WIDTH-1:0]     exp_words [0:`PCI_BUF_DEPTH-1];
  logic [`PCI_AD_WIDTH-1:0]     expected_word;
  logic [`PCI_AD_WIDTH-1:0]     last_ad;
  logic                         last_frame;
  logic [`PCI_BUF_ADDR_WIDTH:0] seen_xfers;
  logic [`PCI_BUF_ADDR_WIDTH:0] burst_len;
  logic                         allow_stop;
  logic                         expect_all;
  logic [15:0]                  data_lfsr;
  int                           frame_cycles;
  int                           error_count = 0;
  int                           timeout_count = 0;
  int                           done_count;
  int                           burst_count = 0;

  pci_master_path i_dut (
    .pci_clk        (pci_clk),
    .pci_reset_comb (pci_reset_comb),
    .host_write     (host_write),
    .host_wdata     (host_wdata),
    .host_addr      (host_addr),
    .host_start     (host_start),
    .pci_gnt        (pci_gnt),
    .pci_resp       (pci_resp),
    .pci_ad_out     (pci_ad_out),
    .pci_ad_oe      (pci_ad_oe),
    .pci_frame_out  (pci_frame_out),
    .pci_irdy_out   (pci_irdy_out),
    .pci_ctl_oe     (pci_ctl_oe),
    .xfer_done      (xfer_done),
    .xfer_words     (xfer_words)
  );

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  // One LFSR step per bit handed out
  task automatic draw_bit(inout logic [15:0] state, output logic bit_out);
    state = lfsr_next(state);
    bit_out = state[0];
  endtask

  initial
  begin
    pci_clk = 1'b0;
    forever #20 pci_clk = ~pci_clk;
  end

  // ======================================================================
  // Target model, answering only while IRDY is out
  // ======================================================================
  initial
  begin : target_model
    logic [15:0] target_lfsr;
    logic        b0, b1, b2, b3, b4;
    target_lfsr = 16'd5;
    pci_resp = '0;
    forever
    begin
      @(posedge pci_clk);
      #2;
      pci_resp = '0;
      if (pci_irdy_out)
      begin
        draw_bit(target_lfsr, b0);
        draw_bit(target_lfsr, b1);
        // Ready three cycles out of four
        pci_resp.trdy = b0 | b1;
        if (allow_stop)
        begin
          draw_bit(target_lfsr, b2);
          draw_bit(target_lfsr, b3);
          draw_bit(target_lfsr, b4);
          pci_resp.stop = b2 & b3 & b4;
        end
      end
    end
  end

  // Bench view of the bus: transfers, FRAME time and previous values
  always @(posedge pci_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      seen_xfers <= '0;
      frame_cycles <= 0;
      last_ad <= '0;
      last_frame <= 1'b0;
      done_count <= 0;
    end
    else
    begin
      last_ad <= pci_ad_out;
      last_frame <= pci_frame_out;
      // A new burst restarts the transfer count at its address phase
      if (pci_frame_out && !last_frame)
        seen_xfers <= '0;
      else if (pci_irdy_out && pci_resp.trdy)
        seen_xfers <= seen_xfers + 1'b1;
      if (!pci_frame_out)
        frame_cycles <= 0;
      else if (frame_cycles < LIMIT)
        frame_cycles <= frame_cycles + 1;
      if (xfer_done)
        done_count <= done_count + 1;
    end
  end

  assign expected_word = exp_words[seen_xfers[`PCI_BUF_ADDR_WIDTH-1:0]];

  // ======================================================================
  // Bus checks
  // ======================================================================
  a_word_order: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (pci_irdy_out && pci_resp.trdy) |-> (pci_ad_out == expected_word))
    else begin error_count++; $display("Error at %0t ns: pci_ad_out expected %h, got %h",
      $time, $sampled(expected_word), $sampled(pci_ad_out)); end
  a_address: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    $rose(pci_frame_out) |-> (pci_ad_out == host_addr && !pci_irdy_out))
    else begin error_count++; $display("Error at %0t ns: pci_ad_out expected address %h, got %h",
      $time, $sampled(host_addr), $sampled(pci_ad_out)); end
  // FRAME is low on the final transfer of a complete burst and only there
  a_frame_last: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (pci_irdy_out && pci_resp.trdy && expect_all)
      |-> (pci_frame_out == (seen_xfers != burst_len - 1'b1)))
    else begin error_count++; $display("Error at %0t ns: pci_frame_out expected %b, got %b",
      $time, !$sampled(pci_frame_out), $sampled(pci_frame_out)); end
  a_frame_fall: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    $fell(pci_frame_out) |-> pci_irdy_out)
    else begin error_count++; $display("Error at %0t ns: pci_irdy_out expected 1, got 0 at FRAME fall",
      $time); end
  a_wait_hold: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (pci_irdy_out && !pci_resp.trdy && !pci_resp.stop)
      |=> (pci_irdy_out && pci_ad_out == last_ad && pci_frame_out == last_frame))
    else begin error_count++; $display("Error at %0t ns: pci_ad_out expected %h, got %h (irdy %b)",
      $time, $sampled(last_ad), $sampled(pci_ad_out), $sampled(pci_irdy_out)); end
  a_burst_end: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (pci_irdy_out && !pci_frame_out && (pci_resp.trdy || pci_resp.stop))
      |=> (!pci_irdy_out && !pci_frame_out))
    else begin error_count++; $display("Error at %0t ns: pci_irdy_out expected 0, got %b",
      $time, $sampled(pci_irdy_out)); end
  a_stop_frame: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (pci_frame_out && pci_irdy_out && pci_resp.stop) |=> !pci_frame_out)
    else begin error_count++; $display("Error at %0t ns: pci_frame_out expected 0, got 1 after STOP",
      $time); end
  a_irdy_fall: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    $fell(pci_irdy_out) |-> !pci_frame_out)
    else begin error_count++; $display("Error at %0t ns: pci_frame_out expected 0, got 1 at IRDY fall",
      $time); end
  a_latency: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (pci_frame_out && pci_irdy_out && pci_resp.trdy && !pci_gnt && frame_cycles >= LIMIT)
      |=> !pci_frame_out)
    else begin error_count++; $display("Error at %0t ns: pci_frame_out expected 0, got 1 after expiry",
      $time); end
  a_oe: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (pci_frame_out || pci_irdy_out) |-> (pci_ad_oe && pci_ctl_oe))
    else begin error_count++; $display("Error at %0t ns: pci_ad_oe/pci_ctl_oe expected 11, got %b%b",
      $time, $sampled(pci_ad_oe), $sampled(pci_ctl_oe)); end
  a_done_pulse: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    xfer_done |=> !xfer_done)
    else begin error_count++; $display("Error at %0t ns: xfer_done expected 0, got 1", $time); end
  a_words_seen: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    xfer_done |-> (xfer_words == seen_xfers))
    else begin error_count++; $display("Error at %0t ns: xfer_words expected %0d, got %0d",
      $time, $sampled(seen_xfers), $sampled(xfer_words)); end
  a_words_all: assert property (@(posedge pci_clk) disable iff (pci_reset_comb)
    (xfer_done && expect_all) |-> (xfer_words == burst_len))
    else begin error_count++; $display("Error at %0t ns: xfer_words expected %0d, got %0d",
      $time, $sampled(burst_len), $sampled(xfer_words)); end

  // ======================================================================
  // Host side
  // ======================================================================
  task automatic load_buffer(input int n);
    logic [`PCI_AD_WIDTH-1:0] word;
    logic                     b;
    for (int i = 0; i < n; i++)
    begin
      word = '0;
      for (int k = 0; k < `PCI_AD_WIDTH; k++)
      begin
        draw_bit(data_lfsr, b);
        word = {word[`PCI_AD_WIDTH-2:0], b};
      end
      exp_words[i[`PCI_BUF_ADDR_WIDTH-1:0]] = word;
      host_wdata = word;
      host_write = 1'b1;
      @(posedge pci_clk);
      #2;
    end
    host_write = 1'b0;
  endtask

  // Write n words, start, optionally take GNT away, and wait for xfer_done
  task automatic run_burst(input int n, input logic stops, input logic drop_gnt);
    int wait_cycles;
    if (timeout_count == 0)
    begin
      load_buffer(n);
      allow_stop = stops;
      expect_all = !stops && !drop_gnt;
      burst_len = (`PCI_BUF_ADDR_WIDTH + 1)'(n);
      host_addr = 32'h4000_0000 | (n << 8);
      host_start = 1'b1;
      @(posedge pci_clk);
      #2;
      host_start = 1'b0;
      burst_count++;
      if (drop_gnt)
      begin
        @(posedge pci_clk);
        #2;
        pci_gnt = 1'b0;
      end
      wait_cycles = 0;
      while (!xfer_done && wait_cycles < TIMEOUT_CYCLES)
      begin
        @(posedge pci_clk);
        #2;
        wait_cycles++;
      end
      pci_gnt = 1'b1;
      if (!xfer_done)
      begin
        timeout_count++;
        $display("Timeout: xfer_done never pulsed for the %0d-word burst", n);
      end
    end
  endtask

  initial
  begin
    pci_reset_comb = 1'b0;
    host_write = 1'b0;
    host_wdata = '0;
    host_addr = '0;
    host_start = 1'b0;
    pci_gnt = 1'b1;
    allow_stop = 1'b0;
    expect_all = 1'b0;
    burst_len = '0;
    data_lfsr = 16'd5;
    #5;
    pci_reset_comb = 1'b1;
    #2;
    // Pads must clear from the reset alone, before the first clock edge
    assert ({pci_ad_out, pci_ad_oe, pci_frame_out, pci_irdy_out, pci_ctl_oe} == '0)
      else begin error_count++; $display("Error at %0t ns: pad outputs expected 0, got %h",
        $time, {pci_ad_out, pci_ad_oe, pci_frame_out, pci_irdy_out, pci_ctl_oe}); end
    repeat (8) @(posedge pci_clk);
    #2;
    pci_reset_comb = 1'b0;
    for (int n = 1; n <= `PCI_BUF_DEPTH; n++)
      run_burst(n, 1'b0, 1'b0);
    for (int n = 10; n <= 15; n++)
      run_burst(n, 1'b1, 1'b0);
    repeat (2) run_burst(`PCI_BUF_DEPTH, 1'b0, 1'b1);
    repeat (4) @(posedge pci_clk);
    #2;
    assert (done_count == burst_count)
      else begin error_count++; $display("Error at %0t ns: done_count expected %0d, got %0d",
        $time, burst_count, done_count); end
    $display("Checks failed: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
src/pci_master_pkg.sv
src/pci_next_signal_decode.sv
src/pci_latency_timer.sv
src/pci_write_buffer.sv
src/pci_output_pads.sv
src/pci_master_sequencer.sv
src/pci_master_path.sv
bench/tb_pci_master_path.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 \
  --top-module tb_pci_master_path \
  -f compile.f -Mdir obj_dir -o tb_sim > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1 \
  || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log \
  && { echo "Simulation FAILED, see sim.log"; exit 1; }
echo "Simulation PASSED"
exit 0
